// ==== hdl/decode_pkg.sv ====
package decode_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////
    localparam int DATA_W    = 32;
    localparam int ADDR_W    = 18; // word address
    localparam int REG_IDX_W = 5;

    typedef logic [DATA_W-1:0]    word_t;
    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [5:0]           opcode_t;
    typedef logic [5:0]           funct_t;

    localparam reg_idx_t LINK_REG = 5'd31; // jal / jalr destination

    //////////////////////////////
    // opcodes
    //////////////////////////////
    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_REGIMM  = 6'b000001;
    localparam opcode_t OP_J       = 6'b000010;
    localparam opcode_t OP_JAL     = 6'b000011;
    localparam opcode_t OP_BEQ     = 6'b000100;
    localparam opcode_t OP_BNE     = 6'b000101;
    localparam opcode_t OP_BLEZ    = 6'b000110;
    localparam opcode_t OP_BGTZ    = 6'b000111;
    localparam opcode_t OP_ADDI    = 6'b001000;
    localparam opcode_t OP_ADDIU   = 6'b001001;
    localparam opcode_t OP_SLTI    = 6'b001010;
    localparam opcode_t OP_SLTIU   = 6'b001011;
    localparam opcode_t OP_ANDI    = 6'b001100;
    localparam opcode_t OP_ORI     = 6'b001101;
    localparam opcode_t OP_XORI    = 6'b001110;
    localparam opcode_t OP_LUI     = 6'b001111;
    localparam opcode_t OP_LB      = 6'b100000;
    localparam opcode_t OP_LH      = 6'b100001;
    localparam opcode_t OP_LW      = 6'b100011;
    localparam opcode_t OP_LBU     = 6'b100100;
    localparam opcode_t OP_LHU     = 6'b100101;
    localparam opcode_t OP_SB      = 6'b101000;
    localparam opcode_t OP_SH      = 6'b101001;
    localparam opcode_t OP_SW      = 6'b101011;

    // funct field of OP_SPECIAL
    localparam funct_t FN_SLL   = 6'b000000;
    localparam funct_t FN_SRL   = 6'b000010;
    localparam funct_t FN_SRA   = 6'b000011;
    localparam funct_t FN_SLLV  = 6'b000100;
    localparam funct_t FN_SRLV  = 6'b000110;
    localparam funct_t FN_SRAV  = 6'b000111;
    localparam funct_t FN_JR    = 6'b001000;
    localparam funct_t FN_JALR  = 6'b001001;
    localparam funct_t FN_MFHI  = 6'b010000;
    localparam funct_t FN_MFLO  = 6'b010010;
    localparam funct_t FN_MULT  = 6'b011000;
    localparam funct_t FN_MULTU = 6'b011001;
    localparam funct_t FN_DIV   = 6'b011010;
    localparam funct_t FN_DIVU  = 6'b011011;
    localparam funct_t FN_ADD   = 6'b100000;
    localparam funct_t FN_ADDU  = 6'b100001;
    localparam funct_t FN_SUB   = 6'b100010;
    localparam funct_t FN_SUBU  = 6'b100011;
    localparam funct_t FN_AND   = 6'b100100;
    localparam funct_t FN_OR    = 6'b100101;
    localparam funct_t FN_XOR   = 6'b100110;
    localparam funct_t FN_NOR   = 6'b100111;
    localparam funct_t FN_SLT   = 6'b101010;
    localparam funct_t FN_SLTU  = 6'b101011;

    // rt field of OP_REGIMM
    localparam reg_idx_t RT_BLTZ = 5'b00000;
    localparam reg_idx_t RT_BGEZ = 5'b00001;

    //////////////////////////////
    // control codes
    //////////////////////////////
    typedef logic [4:0] alu_op_t;
    typedef logic [3:0] mem_op_t;
    typedef logic [1:0] jump_t;

    localparam alu_op_t ALU_NOP  = 5'd0;
    localparam alu_op_t ALU_SLL  = 5'd1;
    localparam alu_op_t ALU_SRL  = 5'd2;
    localparam alu_op_t ALU_SRA  = 5'd3;
    localparam alu_op_t ALU_ADD  = 5'd4;
    localparam alu_op_t ALU_ADDU = 5'd5;
    localparam alu_op_t ALU_SUB  = 5'd6;
    localparam alu_op_t ALU_SUBU = 5'd7;
    localparam alu_op_t ALU_AND  = 5'd8;
    localparam alu_op_t ALU_OR   = 5'd9;
    localparam alu_op_t ALU_XOR  = 5'd10;
    localparam alu_op_t ALU_NOR  = 5'd11;
    localparam alu_op_t ALU_SLT  = 5'd12;
    localparam alu_op_t ALU_SLTU = 5'd13;
    localparam alu_op_t ALU_LU   = 5'd14; // imm << 16
    localparam alu_op_t ALU_MUL  = 5'd15;
    localparam alu_op_t ALU_MULU = 5'd16;
    localparam alu_op_t ALU_DIV  = 5'd17;
    localparam alu_op_t ALU_DIVU = 5'd18;
    localparam alu_op_t ALU_MFHI = 5'd19;
    localparam alu_op_t ALU_MFLO = 5'd20;
    localparam alu_op_t ALU_EQ   = 5'd21; // branch compares
    localparam alu_op_t ALU_NE   = 5'd22;
    localparam alu_op_t ALU_LT   = 5'd23;
    localparam alu_op_t ALU_LE   = 5'd24;
    localparam alu_op_t ALU_GT   = 5'd25;
    localparam alu_op_t ALU_GE   = 5'd26;

    localparam mem_op_t MEM_NONE = 4'd0;
    localparam mem_op_t MEM_LB   = 4'd1;
    localparam mem_op_t MEM_LH   = 4'd2;
    localparam mem_op_t MEM_LW   = 4'd3;
    localparam mem_op_t MEM_LBU  = 4'd4;
    localparam mem_op_t MEM_LHU  = 4'd5;
    localparam mem_op_t MEM_SB   = 4'd6;
    localparam mem_op_t MEM_SH   = 4'd7;
    localparam mem_op_t MEM_SW   = 4'd8;

    localparam jump_t JUMP_NONE = 2'd0;
    localparam jump_t JUMP_IMM  = 2'd1; // target from index field
    localparam jump_t JUMP_REG  = 2'd2; // target from rs

    // all zero means empty decode
    typedef struct packed {
        reg_idx_t rs;
        logic     rs_en;
        reg_idx_t rt;
        logic     rt_en;
        reg_idx_t rd;
        logic     wb_reg;
        word_t    imm;    // immediate or link value
        addr_t    target;
        alu_op_t  alu_op;
        logic     b_imm;  // operand b from imm
        mem_op_t  mem_op;
        jump_t    jump;
        logic     branch;
    } decode_t;

endpackage

// ==== hdl/special_decoder.sv ====
`timescale 1ns/10ps

module special_decoder (
    input  decode_pkg::word_t   inst,
    output logic                hit,
    output decode_pkg::decode_t dec
);
    import decode_pkg::*;

    opcode_t    op;
    reg_idx_t   rs;
    reg_idx_t   rt;
    reg_idx_t   rd;
    logic [4:0] shamt;
    funct_t     fn;
    alu_op_t    fn_alu;

    assign op    = inst[31:26];
    assign rs    = inst[25:21];
    assign rt    = inst[20:16];
    assign rd    = inst[15:11];
    assign shamt = inst[10:6];
    assign fn    = inst[5:0];

    always_comb begin
        case (fn)
            FN_SLL, FN_SLLV: fn_alu = ALU_SLL;
            FN_SRL, FN_SRLV: fn_alu = ALU_SRL;
            FN_SRA, FN_SRAV: fn_alu = ALU_SRA;
            FN_MFHI:  fn_alu = ALU_MFHI;
            FN_MFLO:  fn_alu = ALU_MFLO;
            FN_MULT:  fn_alu = ALU_MUL;
            FN_MULTU: fn_alu = ALU_MULU;
            FN_DIV:   fn_alu = ALU_DIV;
            FN_DIVU:  fn_alu = ALU_DIVU;
            FN_ADD:   fn_alu = ALU_ADD;
            FN_ADDU:  fn_alu = ALU_ADDU;
            FN_SUB:   fn_alu = ALU_SUB;
            FN_SUBU:  fn_alu = ALU_SUBU;
            FN_AND:   fn_alu = ALU_AND;
            FN_OR:    fn_alu = ALU_OR;
            FN_XOR:   fn_alu = ALU_XOR;
            FN_NOR:   fn_alu = ALU_NOR;
            FN_SLT:   fn_alu = ALU_SLT;
            FN_SLTU:  fn_alu = ALU_SLTU;
            default:  fn_alu = ALU_NOP;
        endcase
    end

    always_comb begin
        dec = '0;
        hit = (op == OP_SPECIAL);
        case (fn)
            FN_SLL, FN_SRL, FN_SRA: begin
                dec.rs     = rt; // shifted reg in rs slot
                dec.rs_en  = 1'b1;
                dec.rd     = rd;
                dec.wb_reg = 1'b1;
                dec.imm    = word_t'(shamt);
                dec.b_imm  = 1'b1;
            end
            FN_SLLV, FN_SRLV, FN_SRAV: begin
                dec.rs     = rt;
                dec.rs_en  = 1'b1;
                dec.rt     = rs; // amount register
                dec.rt_en  = 1'b1;
                dec.rd     = rd;
                dec.wb_reg = 1'b1;
            end
            FN_MFHI, FN_MFLO: begin
                dec.rd     = rd;
                dec.wb_reg = 1'b1;
            end
            FN_MULT, FN_MULTU, FN_DIV, FN_DIVU: begin
                dec.rs    = rs; // result goes to hi/lo
                dec.rs_en = 1'b1;
                dec.rt    = rt;
                dec.rt_en = 1'b1;
            end
            FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR,
            FN_XOR, FN_NOR, FN_SLT, FN_SLTU: begin
                dec.rs     = rs;
                dec.rs_en  = 1'b1;
                dec.rt     = rt;
                dec.rt_en  = 1'b1;
                dec.rd     = rd;
                dec.wb_reg = 1'b1;
            end
            default: hit = 1'b0; // jr/jalr live in branch_jump_decoder
        endcase
        dec.alu_op = fn_alu;
        if (!hit || inst == '0) begin
            dec = '0; // miss, or the nop
        end
    end

endmodule

// ==== hdl/branch_jump_decoder.sv ====
`timescale 1ns/10ps

module branch_jump_decoder (
    input  decode_pkg::word_t   inst,
    input  decode_pkg::addr_t   pc,
    output logic                hit,
    output decode_pkg::decode_t dec
);
    import decode_pkg::*;

    opcode_t     op;
    reg_idx_t    rs;
    reg_idx_t    rt;
    funct_t      fn;
    logic [15:0] offset;
    addr_t       br_target;
    addr_t       link_pc;

    assign op     = inst[31:26];
    assign rs     = inst[25:21];
    assign rt     = inst[20:16];
    assign fn     = inst[5:0];
    assign offset = inst[15:0];

    assign br_target = pc + addr_t'(1) + {{(ADDR_W-16){offset[15]}}, offset};
    assign link_pc   = pc + addr_t'(2); // return past the delay slot

    always_comb begin
        dec = '0;
        hit = 1'b1;
        case (op)
            OP_SPECIAL: begin
                dec.rs     = rs;
                dec.rs_en  = 1'b1;
                dec.jump   = JUMP_REG;
                dec.branch = 1'b1;
                case (fn)
                    FN_JR: dec.alu_op = ALU_NOP;
                    FN_JALR: begin
                        dec.rd     = LINK_REG;
                        dec.wb_reg = 1'b1;
                        dec.imm    = word_t'(link_pc);
                        dec.alu_op = ALU_ADDU;
                        dec.b_imm  = 1'b1;
                    end
                    default: hit = 1'b0;
                endcase
            end
            OP_REGIMM: begin
                dec.rs     = rs;
                dec.rs_en  = 1'b1;
                dec.target = br_target;
                dec.branch = 1'b1;
                dec.alu_op = (rt == RT_BLTZ) ? ALU_LT : ALU_GE;
                hit        = (rt == RT_BLTZ) || (rt == RT_BGEZ);
            end
            OP_J, OP_JAL: begin
                dec.target = inst[ADDR_W-1:0]; // index truncated to addr_t
                dec.jump   = JUMP_IMM;
                dec.branch = 1'b1;
                if (op == OP_JAL) begin
                    dec.rd     = LINK_REG;
                    dec.wb_reg = 1'b1;
                    dec.imm    = word_t'(link_pc);
                    dec.alu_op = ALU_ADDU;
                    dec.b_imm  = 1'b1;
                end
            end
            OP_BEQ, OP_BNE: begin
                dec.rs     = rs;
                dec.rs_en  = 1'b1;
                dec.rt     = rt;
                dec.rt_en  = 1'b1;
                dec.target = br_target;
                dec.branch = 1'b1;
                dec.alu_op = (op == OP_BEQ) ? ALU_EQ : ALU_NE;
            end
            OP_BLEZ, OP_BGTZ: begin
                dec.rs     = rs; // compare against zero
                dec.rs_en  = 1'b1;
                dec.target = br_target;
                dec.branch = 1'b1;
                dec.alu_op = (op == OP_BLEZ) ? ALU_LE : ALU_GT;
            end
            default: hit = 1'b0;
        endcase
        if (!hit) begin
            dec = '0;
        end
    end

endmodule

// ==== hdl/imm_mem_decoder.sv ====
`timescale 1ns/10ps

module imm_mem_decoder (
    input  decode_pkg::word_t   inst,
    output logic                hit,
    output decode_pkg::decode_t dec
);
    import decode_pkg::*;

    opcode_t     op;
    reg_idx_t    rs;
    reg_idx_t    rt;
    logic [15:0] imm16;
    word_t       sext_imm;
    word_t       zext_imm;
    logic        zero_ext;
    alu_op_t     op_alu;
    mem_op_t     op_mem;

    assign op    = inst[31:26];
    assign rs    = inst[25:21];
    assign rt    = inst[20:16];
    assign imm16 = inst[15:0];

    assign sext_imm = {{(DATA_W-16){imm16[15]}}, imm16};
    assign zext_imm = {{(DATA_W-16){1'b0}}, imm16};
    assign zero_ext = (op == OP_ANDI) || (op == OP_ORI) || (op == OP_XORI); // logic ops

    always_comb begin
        case (op)
            OP_ADDI:  op_alu = ALU_ADD;
            OP_ADDIU: op_alu = ALU_ADDU;
            OP_SLTI:  op_alu = ALU_SLT;
            OP_SLTIU: op_alu = ALU_SLTU;
            OP_ANDI:  op_alu = ALU_AND;
            OP_ORI:   op_alu = ALU_OR;
            OP_XORI:  op_alu = ALU_XOR;
            OP_LUI:   op_alu = ALU_LU;
            default:  op_alu = ALU_ADD; // address calc for loads/stores
        endcase
        case (op)
            OP_LB:   op_mem = MEM_LB;
            OP_LH:   op_mem = MEM_LH;
            OP_LW:   op_mem = MEM_LW;
            OP_LBU:  op_mem = MEM_LBU;
            OP_LHU:  op_mem = MEM_LHU;
            OP_SB:   op_mem = MEM_SB;
            OP_SH:   op_mem = MEM_SH;
            OP_SW:   op_mem = MEM_SW;
            default: op_mem = MEM_NONE;
        endcase
    end

    always_comb begin
        dec = '0;
        hit = 1'b1;
        dec.alu_op = op_alu;
        dec.mem_op = op_mem;
        dec.b_imm  = 1'b1;
        dec.imm    = sext_imm;
        case (op)
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI: begin
                dec.rs     = rs;
                dec.rs_en  = 1'b1;
                dec.rd     = rt;
                dec.wb_reg = 1'b1;
                dec.imm    = zero_ext ? zext_imm : sext_imm;
            end
            OP_LUI: begin
                dec.rd     = rt; // shift happens in the ALU
                dec.wb_reg = 1'b1;
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
                dec.rs     = rs; // base
                dec.rs_en  = 1'b1;
                dec.rd     = rt;
                dec.wb_reg = 1'b1;
            end
            OP_SB, OP_SH, OP_SW: begin
                dec.rs    = rs;
                dec.rs_en = 1'b1;
                dec.rt    = rt; // store data
                dec.rt_en = 1'b1;
            end
            default: hit = 1'b0;
        endcase
        if (!hit) begin
            dec = '0;
        end
    end

endmodule

// ==== hdl/decode_stage_reg.sv ====
`timescale 1ns/10ps

module decode_stage_reg (
    input  logic                clk,
    input  logic                rst,
    input  logic                inst_valid,
    input  logic                stall,
    input  logic                special_hit,
    input  logic                branch_hit,
    input  logic                imm_mem_hit,
    input  decode_pkg::decode_t special_dec,
    input  decode_pkg::decode_t branch_dec,
    input  decode_pkg::decode_t imm_mem_dec,
    output decode_pkg::decode_t dec,
    output logic                dec_valid,
    output logic                illegal
);
    import decode_pkg::*;

    decode_t sel_dec;
    logic    any_hit;

    assign any_hit = special_hit | branch_hit | imm_mem_hit;

    // decoders are disjoint, so at most one hit
    always_comb begin
        if (special_hit) begin
            sel_dec = special_dec;
        end else if (branch_hit) begin
            sel_dec = branch_dec;
        end else if (imm_mem_hit) begin
            sel_dec = imm_mem_dec;
        end else begin
            sel_dec = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec       <= '0;
            dec_valid <= 1'b0;
            illegal   <= 1'b0;
        end else if (!stall) begin // stall holds everything
            dec       <= inst_valid ? sel_dec : '0;
            dec_valid <= inst_valid;
            illegal   <= inst_valid & ~any_hit;
        end
    end

endmodule

// ==== hdl/inst_decoder_top.sv ====
`timescale 1ns/10ps

module inst_decoder_top (
    input  logic                clk,
    input  logic                rst,
    input  decode_pkg::word_t   raw_inst,
    input  decode_pkg::addr_t   pc,
    input  logic                inst_valid,
    input  logic                stall,
    output decode_pkg::decode_t dec,
    output logic                dec_valid,
    output logic                illegal
);
    import decode_pkg::*;

    logic    special_hit;
    logic    branch_hit;
    logic    imm_mem_hit;
    decode_t special_dec;
    decode_t branch_dec;
    decode_t imm_mem_dec;

    //////////////////////////////
    // decoders
    //////////////////////////////
    special_decoder u_special (
        .inst (raw_inst),
        .hit  (special_hit),
        .dec  (special_dec)
    );

    branch_jump_decoder u_branch (
        .inst (raw_inst),
        .pc   (pc),
        .hit  (branch_hit),
        .dec  (branch_dec)
    );

    imm_mem_decoder u_imm_mem (
        .inst (raw_inst),
        .hit  (imm_mem_hit),
        .dec  (imm_mem_dec)
    );

    //////////////////////////////
    // stage register
    //////////////////////////////
    decode_stage_reg u_stage (
        .clk         (clk),
        .rst         (rst),
        .inst_valid  (inst_valid),
        .stall       (stall),
        .special_hit (special_hit),
        .branch_hit  (branch_hit),
        .imm_mem_hit (imm_mem_hit),
        .special_dec (special_dec),
        .branch_dec  (branch_dec),
        .imm_mem_dec (imm_mem_dec),
        .dec         (dec),
        .dec_valid   (dec_valid),
        .illegal     (illegal)
    );

endmodule

// ==== tests/decode_checker.sv ====
`timescale 1ns/10ps

module decode_checker (
    input  logic                clk,
    input  logic                rst,
    input  decode_pkg::word_t   raw_inst,
    input  decode_pkg::addr_t   pc,
    input  logic                inst_valid,
    input  logic                stall,
    input  decode_pkg::decode_t dec,
    input  logic                dec_valid,
    input  logic                illegal,
    output int                  error_count
);
    import decode_pkg::*;

    decode_t exp_dec;
    logic    exp_valid;
    logic    exp_illegal;
    logic    armed; // set by the first reset edge

    //////////////////////////////
    // reference model
    //////////////////////////////
    function automatic alu_op_t rtype_alu(input funct_t fn);
        case (fn)
            FN_MULT:  return ALU_MUL;
            FN_MULTU: return ALU_MULU;
            FN_DIV:   return ALU_DIV;
            FN_DIVU:  return ALU_DIVU;
            FN_ADD:   return ALU_ADD;
            FN_ADDU:  return ALU_ADDU;
            FN_SUB:   return ALU_SUB;
            FN_SUBU:  return ALU_SUBU;
            FN_AND:   return ALU_AND;
            FN_OR:    return ALU_OR;
            FN_XOR:   return ALU_XOR;
            FN_NOR:   return ALU_NOR;
            FN_SLT:   return ALU_SLT;
            default:  return ALU_SLTU;
        endcase
    endfunction

    function automatic decode_t with_link(input decode_t d, input addr_t pc);
        d.rd     = LINK_REG;
        d.wb_reg = 1'b1;
        d.imm    = {14'b0, pc + 18'd2};
        d.alu_op = ALU_ADDU;
        d.b_imm  = 1'b1;
        return d;
    endfunction

    function automatic decode_t expected_decode(
        input  word_t inst,
        input  addr_t pc,
        output logic  known
    );
        decode_t  d;
        opcode_t  op;
        funct_t   fn;
        reg_idx_t f_rs;
        reg_idx_t f_rt;
        reg_idx_t f_rd;
        word_t    sext;
        addr_t    br_target;
        d         = '0;
        known     = 1'b1;
        op        = inst[31:26];
        fn        = inst[5:0];
        f_rs      = inst[25:21];
        f_rt      = inst[20:16];
        f_rd      = inst[15:11];
        sext      = {{16{inst[15]}}, inst[15:0]};
        br_target = pc + 18'd1 + sext[17:0];
        case (op)
            OP_SPECIAL: begin
                case (fn)
                    FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV: begin
                        d.rs     = f_rt; // shifted reg in rs slot
                        d.rs_en  = 1'b1;
                        d.rd     = f_rd;
                        d.wb_reg = 1'b1;
                        d.alu_op = (fn[1:0] == 2'b00) ? ALU_SLL :
                                   (fn[1:0] == 2'b10) ? ALU_SRL : ALU_SRA;
                        if (fn[2]) begin
                            d.rt    = f_rs; // amount register
                            d.rt_en = 1'b1;
                        end else begin
                            d.imm   = {27'b0, inst[10:6]};
                            d.b_imm = 1'b1;
                        end
                    end
                    FN_JR, FN_JALR: begin
                        d.rs     = f_rs;
                        d.rs_en  = 1'b1;
                        d.jump   = JUMP_REG;
                        d.branch = 1'b1;
                        if (fn == FN_JALR) begin
                            d = with_link(d, pc);
                        end
                    end
                    FN_MFHI, FN_MFLO: begin
                        d.rd     = f_rd;
                        d.wb_reg = 1'b1;
                        d.alu_op = (fn == FN_MFHI) ? ALU_MFHI : ALU_MFLO;
                    end
                    FN_MULT, FN_MULTU, FN_DIV, FN_DIVU,
                    FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR,
                    FN_XOR, FN_NOR, FN_SLT, FN_SLTU: begin
                        d.rs     = f_rs;
                        d.rs_en  = 1'b1;
                        d.rt     = f_rt;
                        d.rt_en  = 1'b1;
                        d.rd     = (fn[5:3] == 3'b011) ? 5'd0 : f_rd; // mul/div to hi/lo
                        d.wb_reg = (fn[5:3] != 3'b011);
                        d.alu_op = rtype_alu(fn);
                    end
                    default: known = 1'b0;
                endcase
            end
            OP_REGIMM: begin
                d.rs     = f_rs;
                d.rs_en  = 1'b1;
                d.target = br_target;
                d.branch = 1'b1;
                d.alu_op = (f_rt == RT_BLTZ) ? ALU_LT : ALU_GE;
                known    = (f_rt == RT_BLTZ) || (f_rt == RT_BGEZ);
            end
            OP_J, OP_JAL: begin
                d.target = inst[17:0];
                d.jump   = JUMP_IMM;
                d.branch = 1'b1;
                if (op == OP_JAL) begin
                    d = with_link(d, pc);
                end
            end
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
                d.rs     = f_rs;
                d.rs_en  = 1'b1;
                d.rt     = op[1] ? 5'd0 : f_rt; // blez/bgtz compare with zero
                d.rt_en  = !op[1];
                d.target = br_target;
                d.branch = 1'b1;
                case (op[1:0])
                    2'b00:   d.alu_op = ALU_EQ;
                    2'b01:   d.alu_op = ALU_NE;
                    2'b10:   d.alu_op = ALU_LE;
                    default: d.alu_op = ALU_GT;
                endcase
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI: begin
                d.rs     = f_rs;
                d.rs_en  = 1'b1;
                d.rd     = f_rt;
                d.wb_reg = 1'b1;
                d.b_imm  = 1'b1;
                d.imm    = op[2] ? {16'b0, inst[15:0]} : sext; // logic ops zero-extend
                case (op)
                    OP_ADDI:  d.alu_op = ALU_ADD;
                    OP_ADDIU: d.alu_op = ALU_ADDU;
                    OP_SLTI:  d.alu_op = ALU_SLT;
                    OP_SLTIU: d.alu_op = ALU_SLTU;
                    OP_ANDI:  d.alu_op = ALU_AND;
                    OP_ORI:   d.alu_op = ALU_OR;
                    default:  d.alu_op = ALU_XOR;
                endcase
            end
            OP_LUI: begin
                d.rd     = f_rt;
                d.wb_reg = 1'b1;
                d.imm    = sext;
                d.b_imm  = 1'b1;
                d.alu_op = ALU_LU;
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW: begin
                d.rs     = f_rs; // base
                d.rs_en  = 1'b1;
                d.imm    = sext;
                d.b_imm  = 1'b1;
                d.alu_op = ALU_ADD;
                if (op[3]) begin
                    d.rt    = f_rt; // store data
                    d.rt_en = 1'b1;
                end else begin
                    d.rd     = f_rt;
                    d.wb_reg = 1'b1;
                end
                case (op)
                    OP_LB:   d.mem_op = MEM_LB;
                    OP_LH:   d.mem_op = MEM_LH;
                    OP_LW:   d.mem_op = MEM_LW;
                    OP_LBU:  d.mem_op = MEM_LBU;
                    OP_LHU:  d.mem_op = MEM_LHU;
                    OP_SB:   d.mem_op = MEM_SB;
                    OP_SH:   d.mem_op = MEM_SH;
                    default: d.mem_op = MEM_SW;
                endcase
            end
            default: known = 1'b0;
        endcase
        if (!known || inst == '0) begin
            d = '0; // illegal, or the nop
        end
        return d;
    endfunction

    //////////////////////////////
    // tracking and compare
    //////////////////////////////
    task automatic compare_value(input string name, input logic [127:0] got,
                                 input logic [127:0] want);
        if (got !== want) begin
            $display("[FAIL] %s got %h expected %h at %0t", name, got, want, $time);
            error_count++;
        end
    endtask

    initial begin
        error_count = 0;
        armed       = 1'b0;
        exp_dec     = '0;
        exp_valid   = 1'b0;
        exp_illegal = 1'b0;
    end

    always @(posedge clk) begin : model_step
        decode_t d;
        logic    known;
        if (rst) begin
            exp_dec     = '0;
            exp_valid   = 1'b0;
            exp_illegal = 1'b0;
            armed       = 1'b1;
        end else if (!stall) begin // stall keeps the old expectation
            d           = expected_decode(raw_inst, pc, known);
            exp_dec     = inst_valid ? d : '0;
            exp_valid   = inst_valid;
            exp_illegal = inst_valid && !known;
        end
    end

    always @(negedge clk) begin
        if (armed) begin
            compare_value("dec", dec, exp_dec);
            compare_value("dec_valid", dec_valid, exp_valid);
            compare_value("illegal", illegal, exp_illegal);
        end
    end

endmodule

// ==== tests/tb_inst_decoder.sv ====
`timescale 1ns/10ps

module tb_inst_decoder;
    import decode_pkg::*;

    localparam int NUM_CYCLES = 3000;
    localparam int WAIT_LIMIT = 20;

    logic    clk;
    logic    rst;
    word_t   raw_inst;
    addr_t   pc;
    logic    inst_valid;
    logic    stall;
    decode_t dec;
    logic    dec_valid;
    logic    illegal;
    int      chk_errors;
    int      timeouts;
    logic    run_ok;

    // legal opcodes besides special, 6 bits each
    logic [23*6-1:0] op_table = {
        OP_REGIMM, OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
        OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW
    };
    logic [24*6-1:0] fn_table = {
        FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_JR, FN_JALR,
        FN_MFHI, FN_MFLO, FN_MULT, FN_MULTU, FN_DIV, FN_DIVU,
        FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU
    };

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    inst_decoder_top DUT (
        .clk        (clk),
        .rst        (rst),
        .raw_inst   (raw_inst),
        .pc         (pc),
        .inst_valid (inst_valid),
        .stall      (stall),
        .dec        (dec),
        .dec_valid  (dec_valid),
        .illegal    (illegal)
    );

    decode_checker u_checker (
        .clk         (clk),
        .rst         (rst),
        .raw_inst    (raw_inst),
        .pc          (pc),
        .inst_valid  (inst_valid),
        .stall       (stall),
        .dec         (dec),
        .dec_valid   (dec_valid),
        .illegal     (illegal),
        .error_count (chk_errors)
    );

    //////////////////////////////
    // stimulus
    //////////////////////////////
    function automatic word_t random_inst();
        word_t w;
        int    k;
        w = $urandom;
        if ($urandom % 8 == 0) begin
            return w; // mostly illegal codes
        end
        if ($urandom % 32 == 0) begin
            return '0; // nop
        end
        if ($urandom % 8 < 3) begin
            k        = $urandom % 24;
            w[31:26] = OP_SPECIAL;
            w[5:0]   = fn_table[k*6 +: 6];
        end else begin
            k        = $urandom % 23;
            w[31:26] = op_table[k*6 +: 6];
            if (w[31:26] == OP_REGIMM) begin
                w[20:16] = ($urandom % 2) ? RT_BGEZ : RT_BLTZ;
            end
        end
        return w;
    endfunction

    task automatic drive_random();
        @(posedge clk);
        #1;
        raw_inst   = random_inst();
        pc         = addr_t'($urandom);
        inst_valid = ($urandom % 8) != 0;
        stall      = ($urandom % 5) == 0;
    endtask

    task automatic wait_dec_valid(input logic level, output logic ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (n < WAIT_LIMIT && !ok) begin
            @(negedge clk);
            if (dec_valid === level) begin
                ok = 1'b1;
            end
            n++;
        end
        if (!ok) begin
            $display("timeout: dec_valid never reached %0b within %0d cycles", level, WAIT_LIMIT);
            timeouts++;
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin
        void'($urandom(32'h19f810e7));
        rst        = 1'b1;
        raw_inst   = '0;
        pc         = '0;
        inst_valid = 1'b0;
        stall      = 1'b0;
        timeouts   = 0;
        repeat (5) @(posedge clk);
        #1;
        rst        = 1'b0;
        raw_inst   = {OP_ADDIU, 5'd3, 5'd4, 16'h8001}; // first accepted instruction
        pc         = 18'h00100;
        inst_valid = 1'b1;
        wait_dec_valid(1'b1, run_ok);
        if (run_ok) begin
            repeat (NUM_CYCLES) drive_random();
            @(posedge clk);
            #1;
            inst_valid = 1'b0;
            stall      = 1'b0;
            wait_dec_valid(1'b0, run_ok); // drain
        end
        @(negedge clk);
        #1;
        $display("run done: %0d check errors, %0d timeouts", chk_errors, timeouts);
        if (chk_errors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
hdl/decode_pkg.sv
hdl/special_decoder.sv
hdl/branch_jump_decoder.sv
hdl/imm_mem_decoder.sv
hdl/decode_stage_reg.sv
hdl/inst_decoder_top.sv
tests/decode_checker.sv
tests/tb_inst_decoder.sv

// ==== Bender.yml ====
package:
  name: inst_decoder

sources:
  - hdl/decode_pkg.sv
  - hdl/special_decoder.sv
  - hdl/branch_jump_decoder.sv
  - hdl/imm_mem_decoder.sv
  - hdl/decode_stage_reg.sv
  - hdl/inst_decoder_top.sv
  - target: test
    files:
      - tests/decode_checker.sv
      - tests/tb_inst_decoder.sv
